//--- include/int_issue_defines.svh
`ifndef INT_ISSUE_DEFINES_SVH
`define INT_ISSUE_DEFINES_SVH

// Banks, dispatch slots and issue ports are all one per ALU
`define INT_ISSUE_ALU_NUM 2

// Total entries, split evenly over the banks
`define INT_ISSUE_SIZE 8

`define INT_ISSUE_WB_NUM 2

`define INT_ISSUE_PREG_WIDTH 6

`define INT_ISSUE_XLEN 32

`endif

//--- hdl/int_issue_pkg.sv
`default_nettype none

`include "int_issue_defines.svh"

package int_issue_pkg;

    typedef logic [`INT_ISSUE_PREG_WIDTH-1:0] preg_t;

    typedef struct packed {
        preg_t rs1;
        preg_t rs2;
        logic  rs1_v;
        logic  rs2_v;
    } issue_status_t;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SLT, SLL, SRL} alu_op_e;

    typedef enum logic [2:0] {NONE_BR, BEQ, BNE, BLT, BGE, JAL, JALR} branch_op_e;

    typedef struct packed {
        logic [4:0]  rsvd;
        alu_op_e     alu_op;
        logic [11:0] imm;
    } alu_view_t;

    typedef struct packed {
        logic [4:0]  rsvd;
        branch_op_e  branch_op;
        logic [11:0] offset;
    } branch_view_t;

    // The same 20 bits read as an ALU op or a branch op, chosen by is_branch
    typedef union packed {
        alu_view_t    alu;
        branch_view_t branch;
    } uop_payload_u;

    typedef struct packed {
        preg_t        rd;
        logic [4:0]   arch_rd;
        logic [4:0]   arch_rs1;
        logic         is_branch;
        uop_payload_u payload;
    } int_uop_t;

    typedef enum logic [1:0] {CONDITION, DIRECT, INDIRECT, CALL} br_type_e;

    typedef enum logic [1:0] {RAS_NONE, RAS_POP, RAS_PUSH, RAS_POP_PUSH} ras_type_e;

endpackage

`default_nettype wire

//--- hdl/int_issue_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_issue_defines.svh"

module int_issue_bank
    import int_issue_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst_i,
    input  wire logic                                    en_i,
    input  wire issue_status_t                           status_i,
    input  wire int_uop_t                                uop_i,
    input  wire logic [`INT_ISSUE_WB_NUM-1:0]            wb_en_i,
    input  wire preg_t [`INT_ISSUE_WB_NUM-1:0]           wb_rd_i,
    output logic                                         full_o,
    output logic [$clog2(DEPTH):0]                       count_o,
    output logic                                         sel_valid_o,
    output issue_status_t                                sel_status_o,
    output int_uop_t                                     sel_uop_o
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    logic [DEPTH-1:0] valid_q;
    issue_status_t    status_q [DEPTH];
    int_uop_t         uop_q [DEPTH];

    logic [DEPTH-1:0] ready;
    logic [DEPTH-1:0] rs1_hit;
    logic [DEPTH-1:0] rs2_hit;
    logic             in_rs1_hit;
    logic             in_rs2_hit;
    issue_status_t    status_in;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             alloc;

    // Tag compare against every writeback port, for stored entries and the incoming one
    always_comb begin
        rs1_hit    = '0;
        rs2_hit    = '0;
        in_rs1_hit = 1'b0;
        in_rs2_hit = 1'b0;
        for (int w = 0; w < `INT_ISSUE_WB_NUM; w++) begin
            if (wb_en_i[w]) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (wb_rd_i[w] == status_q[i].rs1) rs1_hit[i] = 1'b1;
                    if (wb_rd_i[w] == status_q[i].rs2) rs2_hit[i] = 1'b1;
                end
                if (wb_rd_i[w] == status_i.rs1) in_rs1_hit = 1'b1;
                if (wb_rd_i[w] == status_i.rs2) in_rs2_hit = 1'b1;
            end
        end
    end

    always_comb begin
        status_in       = status_i;
        status_in.rs1_v = status_i.rs1_v | in_rs1_hit;
        status_in.rs2_v = status_i.rs2_v | in_rs2_hit;
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ready[i] = valid_q[i] & status_q[i].rs1_v & status_q[i].rs2_v;
        end
    end

    // Downward scans, so the lowest index is the one that sticks
    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) free_idx = IDX_W'(i);
            if (ready[i]) sel_idx = IDX_W'(i);
        end
    end

    always_comb begin
        count_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            count_o = count_o + CNT_W'(valid_q[i]);
        end
    end

    assign full_o       = &valid_q;
    assign alloc        = en_i & ~full_o;
    assign sel_valid_o  = |ready;
    assign sel_status_o = status_q[sel_idx];
    assign sel_uop_o    = uop_q[sel_idx];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (sel_valid_o && sel_idx == IDX_W'(i)) valid_q[i] <= 1'b0;
                if (alloc && free_idx == IDX_W'(i)) valid_q[i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (rs1_hit[i]) status_q[i].rs1_v <= 1'b1;
            if (rs2_hit[i]) status_q[i].rs2_v <= 1'b1;
        end
        if (alloc) begin
            status_q[free_idx] <= status_in; // Overrides any wakeup on the free slot
            uop_q[free_idx]    <= uop_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bank_order_sort.sv
`timescale 1ns/100ps
`default_nettype none

module bank_order_sort #(
    parameter int NUM       = 2,
    parameter int CNT_WIDTH = 3
) (
    input  wire logic                                          clk,
    input  wire logic                                          rst_i,
    input  wire logic [NUM-1:0][CNT_WIDTH-1:0]                 count_i,
    output logic [NUM-1:0][((NUM > 1) ? $clog2(NUM) : 1)-1:0]  order_o
);

    localparam int IDX_W = (NUM > 1) ? $clog2(NUM) : 1;

    logic [IDX_W-1:0]            rank [NUM];
    logic [NUM-1:0][IDX_W-1:0]   order_d;

    // Rank of a bank is the number of banks that sort ahead of it
    always_comb begin
        for (int i = 0; i < NUM; i++) begin
            rank[i] = '0;
            for (int j = 0; j < NUM; j++) begin
                if (count_i[j] < count_i[i] || (count_i[j] == count_i[i] && j < i)) begin
                    rank[i] = rank[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        order_d = '0;
        for (int i = 0; i < NUM; i++) begin
            order_d[rank[i]] = IDX_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM; i++) begin
                order_o[i] <= IDX_W'(i);
            end
        end else begin
            order_o <= order_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/branch_classifier.sv
`timescale 1ns/100ps
`default_nettype none

module branch_classifier
    import int_issue_pkg::*;
(
    input  wire int_uop_t uop_i,
    output br_type_e      br_type_o,
    output ras_type_e     ras_type_o
);

    logic       push;
    logic       pop;
    logic       is_jalr;
    branch_op_e op;

    assign op      = uop_i.payload.branch.branch_op;
    assign is_jalr = uop_i.is_branch && op == JALR;

    // x1 and x5 are the link registers
    assign push = uop_i.is_branch && (uop_i.arch_rd == 5'd1 || uop_i.arch_rd == 5'd5);
    assign pop  = is_jalr && (uop_i.arch_rs1 == 5'd1 || uop_i.arch_rs1 == 5'd5);

    always_comb begin
        case ({push, pop})
            2'b01:   ras_type_o = RAS_POP;
            2'b10:   ras_type_o = RAS_PUSH;
            2'b11:   ras_type_o = RAS_POP_PUSH;
            default: ras_type_o = RAS_NONE;
        endcase
    end

    always_comb begin
        if (uop_i.is_branch && op == JAL) begin
            br_type_o = DIRECT;
        end else if (is_jalr) begin
            br_type_o = (push || pop) ? CALL : INDIRECT;
        end else begin
            br_type_o = CONDITION; // Also the value for ALU ops, which nobody looks at
        end
    end

endmodule

`default_nettype wire

//--- hdl/int_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_issue_defines.svh"

module int_issue_queue
    import int_issue_pkg::*;
(
    input  wire logic                                               clk,
    input  wire logic                                               rst_i,
    input  wire logic [`INT_ISSUE_ALU_NUM-1:0]                      dis_en_i,
    input  wire issue_status_t [`INT_ISSUE_ALU_NUM-1:0]             dis_status_i,
    input  wire int_uop_t [`INT_ISSUE_ALU_NUM-1:0]                  dis_uop_i,
    output logic                                                    dis_full_o,
    input  wire logic [`INT_ISSUE_WB_NUM-1:0]                       wb_en_i,
    input  wire preg_t [`INT_ISSUE_WB_NUM-1:0]                      wb_rd_i,
    output preg_t [`INT_ISSUE_ALU_NUM-1:0]                          rf_rs1_o,
    output preg_t [`INT_ISSUE_ALU_NUM-1:0]                          rf_rs2_o,
    input  wire logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0] rf_rs1_data_i,
    input  wire logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0] rf_rs2_data_i,
    output logic [`INT_ISSUE_ALU_NUM-1:0]                           issue_valid_o,
    output int_uop_t [`INT_ISSUE_ALU_NUM-1:0]                       issue_uop_o,
    output logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]      issue_rs1_data_o,
    output logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]      issue_rs2_data_o,
    output br_type_e [`INT_ISSUE_ALU_NUM-1:0]                       issue_br_type_o,
    output ras_type_e [`INT_ISSUE_ALU_NUM-1:0]                      issue_ras_type_o
);

    localparam int BANK_NUM   = `INT_ISSUE_ALU_NUM;
    localparam int BANK_DEPTH = `INT_ISSUE_SIZE / `INT_ISSUE_ALU_NUM;
    localparam int CNT_W      = $clog2(BANK_DEPTH) + 1;
    localparam int ORD_W      = (BANK_NUM > 1) ? $clog2(BANK_NUM) : 1;

    logic [BANK_NUM-1:0][ORD_W-1:0] order;
    logic [BANK_NUM-1:0][CNT_W-1:0] bank_count;
    logic [BANK_NUM-1:0]            bank_full;
    logic [BANK_NUM-1:0]            bank_en;
    issue_status_t [BANK_NUM-1:0]   bank_status;
    int_uop_t [BANK_NUM-1:0]        bank_uop;
    logic [BANK_NUM-1:0]            sel_valid;
    issue_status_t [BANK_NUM-1:0]   sel_status;
    int_uop_t [BANK_NUM-1:0]        sel_uop;
    br_type_e [BANK_NUM-1:0]        sel_br_type;
    ras_type_e [BANK_NUM-1:0]       sel_ras_type;

    // Any enabled slot aimed at a full bank stalls the whole dispatch group
    always_comb begin
        dis_full_o = 1'b0;
        for (int k = 0; k < BANK_NUM; k++) begin
            if (dis_en_i[k] && bank_full[order[k]]) dis_full_o = 1'b1;
        end
    end

    // Slot k lands in the bank at position k of the order
    always_comb begin
        bank_en     = '0;
        bank_status = '0;
        bank_uop    = '0;
        for (int k = 0; k < BANK_NUM; k++) begin
            bank_en[order[k]]     = dis_en_i[k] & ~dis_full_o;
            bank_status[order[k]] = dis_status_i[k];
            bank_uop[order[k]]    = dis_uop_i[k];
        end
    end

    for (genvar b = 0; b < BANK_NUM; b++) begin : g_bank
        int_issue_bank #(
            .DEPTH (BANK_DEPTH)
        ) u_bank (
            .clk          (clk),
            .rst_i        (rst_i),
            .en_i         (bank_en[b]),
            .status_i     (bank_status[b]),
            .uop_i        (bank_uop[b]),
            .wb_en_i      (wb_en_i),
            .wb_rd_i      (wb_rd_i),
            .full_o       (bank_full[b]),
            .count_o      (bank_count[b]),
            .sel_valid_o  (sel_valid[b]),
            .sel_status_o (sel_status[b]),
            .sel_uop_o    (sel_uop[b])
        );

        branch_classifier u_classifier (
            .uop_i      (sel_uop[b]),
            .br_type_o  (sel_br_type[b]),
            .ras_type_o (sel_ras_type[b])
        );

        assign rf_rs1_o[b] = sel_status[b].rs1;
        assign rf_rs2_o[b] = sel_status[b].rs2;
    end

    bank_order_sort #(
        .NUM       (BANK_NUM),
        .CNT_WIDTH (CNT_W)
    ) u_order_sort (
        .clk     (clk),
        .rst_i   (rst_i),
        .count_i (bank_count),
        .order_o (order)
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_valid_o <= '0;
        end else begin
            issue_valid_o <= sel_valid;
        end
    end

    // Bank b always feeds ALU b
    always_ff @(posedge clk) begin
        for (int b = 0; b < BANK_NUM; b++) begin
            if (sel_valid[b]) begin
                issue_uop_o[b]      <= sel_uop[b];
                issue_rs1_data_o[b] <= rf_rs1_data_i[b];
                issue_rs2_data_o[b] <= rf_rs2_data_i[b];
                issue_br_type_o[b]  <= sel_br_type[b];
                issue_ras_type_o[b] <= sel_ras_type[b];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/phys_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_issue_defines.svh"

module phys_regfile
    import int_issue_pkg::*;
(
    input  wire logic                                               clk,
    input  wire logic                                               rst_i,
    input  wire logic [`INT_ISSUE_WB_NUM-1:0]                       wb_en_i,
    input  wire preg_t [`INT_ISSUE_WB_NUM-1:0]                      wb_rd_i,
    input  wire logic [`INT_ISSUE_WB_NUM-1:0][`INT_ISSUE_XLEN-1:0]  wb_data_i,
    input  wire preg_t [`INT_ISSUE_ALU_NUM-1:0]                     rd_rs1_i,
    input  wire preg_t [`INT_ISSUE_ALU_NUM-1:0]                     rd_rs2_i,
    output logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]      rd_rs1_data_o,
    output logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]      rd_rs2_data_o
);

    localparam int NUM_REGS = 1 << `INT_ISSUE_PREG_WIDTH;

    logic [`INT_ISSUE_XLEN-1:0] regs [NUM_REGS];

    // Later ports are written last and so take priority on a shared tag
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < `INT_ISSUE_WB_NUM; w++) begin
                if (wb_en_i[w]) regs[wb_rd_i[w]] <= wb_data_i[w];
            end
        end
    end

    always_comb begin
        for (int a = 0; a < `INT_ISSUE_ALU_NUM; a++) begin
            rd_rs1_data_o[a] = regs[rd_rs1_i[a]];
            rd_rs2_data_o[a] = regs[rd_rs2_i[a]];
            for (int w = 0; w < `INT_ISSUE_WB_NUM; w++) begin
                if (wb_en_i[w] && wb_rd_i[w] == rd_rs1_i[a]) rd_rs1_data_o[a] = wb_data_i[w];
                if (wb_en_i[w] && wb_rd_i[w] == rd_rs2_i[a]) rd_rs2_data_o[a] = wb_data_i[w];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/int_issue_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_issue_defines.svh"

module int_issue_top
    import int_issue_pkg::*;
(
    input  wire logic                                               clk,
    input  wire logic                                               rst_i,
    input  wire logic [`INT_ISSUE_ALU_NUM-1:0]                      dis_en_i,
    input  wire issue_status_t [`INT_ISSUE_ALU_NUM-1:0]             dis_status_i,
    input  wire int_uop_t [`INT_ISSUE_ALU_NUM-1:0]                  dis_uop_i,
    output logic                                                    dis_full_o,
    input  wire logic [`INT_ISSUE_WB_NUM-1:0]                       wb_en_i,
    input  wire preg_t [`INT_ISSUE_WB_NUM-1:0]                      wb_rd_i,
    input  wire logic [`INT_ISSUE_WB_NUM-1:0][`INT_ISSUE_XLEN-1:0]  wb_data_i,
    output logic [`INT_ISSUE_ALU_NUM-1:0]                           issue_valid_o,
    output int_uop_t [`INT_ISSUE_ALU_NUM-1:0]                       issue_uop_o,
    output logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]      issue_rs1_data_o,
    output logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]      issue_rs2_data_o,
    output br_type_e [`INT_ISSUE_ALU_NUM-1:0]                       issue_br_type_o,
    output ras_type_e [`INT_ISSUE_ALU_NUM-1:0]                      issue_ras_type_o
);

    preg_t [`INT_ISSUE_ALU_NUM-1:0]                      rf_rs1;
    preg_t [`INT_ISSUE_ALU_NUM-1:0]                      rf_rs2;
    logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]  rf_rs1_data;
    logic [`INT_ISSUE_ALU_NUM-1:0][`INT_ISSUE_XLEN-1:0]  rf_rs2_data;

    int_issue_queue u_queue (
        .clk              (clk),
        .rst_i            (rst_i),
        .dis_en_i         (dis_en_i),
        .dis_status_i     (dis_status_i),
        .dis_uop_i        (dis_uop_i),
        .dis_full_o       (dis_full_o),
        .wb_en_i          (wb_en_i),
        .wb_rd_i          (wb_rd_i),
        .rf_rs1_o         (rf_rs1),
        .rf_rs2_o         (rf_rs2),
        .rf_rs1_data_i    (rf_rs1_data),
        .rf_rs2_data_i    (rf_rs2_data),
        .issue_valid_o    (issue_valid_o),
        .issue_uop_o      (issue_uop_o),
        .issue_rs1_data_o (issue_rs1_data_o),
        .issue_rs2_data_o (issue_rs2_data_o),
        .issue_br_type_o  (issue_br_type_o),
        .issue_ras_type_o (issue_ras_type_o)
    );

    phys_regfile u_regfile (
        .clk           (clk),
        .rst_i         (rst_i),
        .wb_en_i       (wb_en_i),
        .wb_rd_i       (wb_rd_i),
        .wb_data_i     (wb_data_i),
        .rd_rs1_i      (rf_rs1),
        .rd_rs2_i      (rf_rs2),
        .rd_rs1_data_o (rf_rs1_data),
        .rd_rs2_data_o (rf_rs2_data)
    );

endmodule

`default_nettype wire

//--- verification/int_issue_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "int_issue_defines.svh"

module int_issue_tb
    import int_issue_pkg::*;
();

    localparam int ALU      = `INT_ISSUE_ALU_NUM;
    localparam int WB       = `INT_ISSUE_WB_NUM;
    localparam int NUM_TAGS = 1 << `INT_ISSUE_PREG_WIDTH;
    localparam int NEVER    = 32'h7fff_ffff;

    typedef logic [`INT_ISSUE_XLEN-1:0] word_t;

    typedef struct {
        logic [ALU-1:0]          en;
        issue_status_t [ALU-1:0] status;
        int_uop_t [ALU-1:0]      uop;
        logic [WB-1:0]           wb_en;
        preg_t [WB-1:0]          wb_rd;
        logic                    exp_full;
    } step_t;

    logic                    clk;
    logic                    rst_i;
    logic [ALU-1:0]          dis_en;
    issue_status_t [ALU-1:0] dis_status;
    int_uop_t [ALU-1:0]      dis_uop;
    logic                    dis_full;
    logic [WB-1:0]           wb_en;
    preg_t [WB-1:0]          wb_rd;
    word_t [WB-1:0]          wb_data;
    logic [ALU-1:0]          issue_valid;
    int_uop_t [ALU-1:0]      issue_uop;
    word_t [ALU-1:0]         issue_rs1_data;
    word_t [ALU-1:0]         issue_rs2_data;
    br_type_e [ALU-1:0]      issue_br_type;
    ras_type_e [ALU-1:0]     issue_ras_type;

    step_t     steps [$];
    logic [31:0] lfsr_state;
    int        cycles;
    int        cycle_limit;
    int        pending_cnt;

    // Scoreboard state is indexed by the rd tag of each micro-op
    word_t     ref_rf [NUM_TAGS];
    logic      pend_valid [NUM_TAGS];
    logic      issued [NUM_TAGS];
    int_uop_t  exp_uop [NUM_TAGS];
    br_type_e  exp_br [NUM_TAGS];
    ras_type_e exp_ras [NUM_TAGS];
    preg_t     src1 [NUM_TAGS];
    preg_t     src2 [NUM_TAGS];
    int        disp_step [NUM_TAGS];
    int        rdy1 [NUM_TAGS];
    int        rdy2 [NUM_TAGS];

    int_issue_top dut (
        .clk              (clk),
        .rst_i            (rst_i),
        .dis_en_i         (dis_en),
        .dis_status_i     (dis_status),
        .dis_uop_i        (dis_uop),
        .dis_full_o       (dis_full),
        .wb_en_i          (wb_en),
        .wb_rd_i          (wb_rd),
        .wb_data_i        (wb_data),
        .issue_valid_o    (issue_valid),
        .issue_uop_o      (issue_uop),
        .issue_rs1_data_o (issue_rs1_data),
        .issue_rs2_data_o (issue_rs2_data),
        .issue_br_type_o  (issue_br_type),
        .issue_ras_type_o (issue_ras_type)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (pend_valid[t]) $display("Micro-op with rd tag %0d was never issued", t);
            end
            abort_run($sformatf("Timeout after %0d cycles", cycles));
        end
    end

    // Galois LFSR that takes one step per bit handed out
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_uop(input string name, input int_uop_t exp, input int_uop_t act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_br(input string name, input br_type_e exp, input br_type_e act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    task automatic check_ras(input string name, input ras_type_e exp, input ras_type_e act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s: expected %s, actual %s", name, exp.name(), act.name()));
        end
    endtask

    function automatic issue_status_t srcs(input preg_t rs1, input logic v1,
                                           input preg_t rs2, input logic v2);
        issue_status_t s;
        s.rs1   = rs1;
        s.rs1_v = v1;
        s.rs2   = rs2;
        s.rs2_v = v2;
        return s;
    endfunction

    // Non-branch ops classify as CONDITION with no RAS action, whatever arch_rd holds
    function automatic int_uop_t alu_uop(input preg_t rd, input alu_op_e op);
        int_uop_t u;
        u                    = '0;
        u.rd                 = rd;
        u.arch_rd            = 5'(lfsr_bits(5));
        u.arch_rs1           = 5'(lfsr_bits(5));
        u.payload.alu.alu_op = op;
        u.payload.alu.imm    = 12'(lfsr_bits(12));
        exp_br[rd]           = CONDITION;
        exp_ras[rd]          = RAS_NONE;
        return u;
    endfunction

    function automatic int_uop_t br_uop(input preg_t rd, input branch_op_e op,
                                        input logic [4:0] ard, input logic [4:0] ars1,
                                        input br_type_e br, input ras_type_e ras);
        int_uop_t u;
        u                          = '0;
        u.rd                       = rd;
        u.arch_rd                  = ard;
        u.arch_rs1                 = ars1;
        u.is_branch                = 1'b1;
        u.payload.branch.branch_op = op;
        u.payload.branch.offset    = 12'(lfsr_bits(12));
        exp_br[rd]                 = br;
        exp_ras[rd]                = ras;
        return u;
    endfunction

    task automatic add_step(
        input logic [ALU-1:0] en,
        input issue_status_t  s0,
        input int_uop_t       u0,
        input issue_status_t  s1,
        input int_uop_t       u1,
        input logic [WB-1:0]  wbe,
        input preg_t          wb0,
        input preg_t          wb1,
        input logic           full
    );
        step_t s;
        s.en        = en;
        s.status[0] = s0;
        s.uop[0]    = u0;
        s.status[1] = s1;
        s.uop[1]    = u1;
        s.wb_en     = wbe;
        s.wb_rd[0]  = wb0;
        s.wb_rd[1]  = wb1;
        s.exp_full  = full;
        steps.push_back(s);
    endtask

    task automatic add_idle(input int n);
        repeat (n) add_step('0, '0, '0, '0, '0, '0, 0, 0, 1'b0);
    endtask

    task automatic build_table();
        add_idle(3);
        add_step('0, '0, '0, '0, '0, 2'b11, 1, 2, 1'b0);
        add_step('0, '0, '0, '0, '0, 2'b11, 3, 4, 1'b0);
        add_step(2'b11, srcs(1, 1, 2, 1), alu_uop(32, ADD),
                 srcs(3, 1, 4, 1), alu_uop(33, XOR), '0, 0, 0, 1'b0);
        add_step(2'b01, srcs(2, 1, 3, 1), alu_uop(34, SLL), '0, '0, '0, 0, 0, 1'b0);
        add_idle(2);
        // Tag 5 is written three steps after dispatch
        add_step(2'b01, srcs(5, 0, 1, 1), alu_uop(35, SUB), '0, '0, '0, 0, 0, 1'b0);
        add_idle(2);
        add_step('0, '0, '0, '0, '0, 2'b01, 5, 0, 1'b0);
        add_step(2'b10, '0, '0, srcs(6, 0, 7, 0), alu_uop(36, SLT), 2'b11, 6, 7, 1'b0);
        add_idle(3);
        add_step(2'b11, srcs(1, 1, 2, 1), br_uop(37, JAL, 5'd1, 5'd0, DIRECT, RAS_PUSH),
                 srcs(3, 1, 0, 1), br_uop(38, JALR, 5'd0, 5'd5, CALL, RAS_POP),
                 '0, 0, 0, 1'b0);
        add_step(2'b11, srcs(4, 1, 1, 1), br_uop(39, JALR, 5'd0, 5'd10, INDIRECT, RAS_NONE),
                 srcs(2, 1, 3, 1), br_uop(40, BEQ, 5'd0, 5'd0, CONDITION, RAS_NONE),
                 '0, 0, 0, 1'b0);
        add_step(2'b01, srcs(4, 1, 4, 1), br_uop(41, JALR, 5'd5, 5'd1, CALL, RAS_POP_PUSH),
                 '0, '0, '0, 0, 0, 1'b0);
        add_idle(3);
        // Four dual dispatches of waiting ops fill both banks
        for (int n = 0; n < 4; n++) begin
            add_step(2'b11, srcs(8 + 2 * n, 0, 1, 1), alu_uop(42 + 2 * n, OR),
                     srcs(9 + 2 * n, 0, 2, 1), alu_uop(43 + 2 * n, AND), '0, 0, 0, 1'b0);
        end
        add_step(2'b01, srcs(1, 1, 2, 1), alu_uop(50, ADD), '0, '0, '0, 0, 0, 1'b1);
        add_step(2'b10, '0, '0, srcs(3, 1, 4, 1), alu_uop(51, ADD), '0, 0, 0, 1'b1);
        for (int n = 0; n < 4; n++) begin
            add_step('0, '0, '0, '0, '0, 2'b11, 8 + 2 * n, 9 + 2 * n, 1'b0);
        end
        add_idle(2);
        add_step(2'b11, srcs(8, 1, 15, 1), alu_uop(52, SRL),
                 srcs(0, 1, 11, 1), alu_uop(53, ADD), '0, 0, 0, 1'b0);
        add_idle(2);
    endtask

    // Outputs seen at step i come from a select made during step i - 1
    task automatic sample_issue(input int i);
        int tag;
        int elig;
        for (int a = 0; a < ALU; a++) begin
            if (issue_valid[a] === 1'b1) begin
                tag = int'(issue_uop[a].rd);
                if (issued[tag]) begin
                    abort_run($sformatf("Micro-op with rd tag %0d issued twice", tag));
                end else if (!pend_valid[tag]) begin
                    abort_run($sformatf("ALU %0d issued rd tag %0d, which was never accepted",
                                        a, tag));
                end else begin
                    elig = disp_step[tag];
                    if (rdy1[tag] > elig) elig = rdy1[tag];
                    if (rdy2[tag] > elig) elig = rdy2[tag];
                    if (elig > i - 2) begin
                        abort_run($sformatf("Rd tag %0d issued before its sources were ready",
                                            tag));
                    end
                    check_uop($sformatf("rd %0d uop", tag), exp_uop[tag], issue_uop[a]);
                    check_word($sformatf("rd %0d rs1 data", tag), ref_rf[src1[tag]],
                               issue_rs1_data[a]);
                    check_word($sformatf("rd %0d rs2 data", tag), ref_rf[src2[tag]],
                               issue_rs2_data[a]);
                    check_br($sformatf("rd %0d br_type", tag), exp_br[tag], issue_br_type[a]);
                    check_ras($sformatf("rd %0d ras_type", tag), exp_ras[tag],
                              issue_ras_type[a]);
                    pend_valid[tag] = 1'b0;
                    issued[tag]     = 1'b1;
                    pending_cnt--;
                end
            end
        end
    endtask

    task automatic apply_step(input step_t s, input int i);
        int    t;
        preg_t rd;
        dis_en     = s.en;
        dis_status = s.status;
        dis_uop    = s.uop;
        wb_en      = s.wb_en;
        wb_rd      = s.wb_rd;
        for (int p = 0; p < WB; p++) begin
            wb_data[p] = s.wb_en[p] ? lfsr_bits(32) : '0;
        end
        #1;
        // Full can only rise when some slot is enabled
        if (s.en != '0) check_bit($sformatf("dis_full step %0d", i), s.exp_full, dis_full);
        if (!s.exp_full) begin
            for (int k = 0; k < ALU; k++) begin
                if (s.en[k]) begin
                    t            = int'(s.uop[k].rd);
                    pend_valid[t] = 1'b1;
                    exp_uop[t]   = s.uop[k];
                    disp_step[t] = i;
                    src1[t]      = s.status[k].rs1;
                    src2[t]      = s.status[k].rs2;
                    rdy1[t]      = s.status[k].rs1_v ? i : NEVER;
                    rdy2[t]      = s.status[k].rs2_v ? i : NEVER;
                    pending_cnt++;
                end
            end
        end
        // A writeback wakes waiting sources at the same edge, new arrivals included
        for (int p = 0; p < WB; p++) begin
            if (s.wb_en[p]) begin
                rd         = s.wb_rd[p];
                ref_rf[rd] = wb_data[p];
                for (t = 0; t < NUM_TAGS; t++) begin
                    if (pend_valid[t] && src1[t] == rd && rdy1[t] == NEVER) rdy1[t] = i;
                    if (pend_valid[t] && src2[t] == rd && rdy2[t] == NEVER) rdy2[t] = i;
                end
            end
        end
    endtask

    initial begin
        step_t idle;
        int    j;
        rst_i       = 1'b1;
        dis_en      = '0;
        dis_status  = '0;
        dis_uop     = '0;
        wb_en       = '0;
        wb_rd       = '0;
        wb_data     = '0;
        lfsr_state  = 32'hc967_1b3d;
        cycles      = 0;
        cycle_limit = 0;
        pending_cnt = 0;
        idle        = '{default: '0};
        for (int t = 0; t < NUM_TAGS; t++) begin
            ref_rf[t]     = '0;
            pend_valid[t] = 1'b0;
            issued[t]     = 1'b0;
        end
        build_table();
        cycle_limit = steps.size() * 8 + 50;

        repeat (4) @(posedge clk);
        @(negedge clk);
        dis_en = '1; // Reset still holds here and no slot can be accepted
        #1;
        check_bit("dis_full after reset", 1'b0, dis_full);
        for (int a = 0; a < ALU; a++) begin
            check_bit($sformatf("issue_valid[%0d] after reset", a), 1'b0, issue_valid[a]);
        end
        dis_en = '0;
        rst_i  = 1'b0;

        foreach (steps[i]) begin
            @(negedge clk);
            sample_issue(i);
            apply_step(steps[i], i);
        end
        j = steps.size();
        while (pending_cnt > 0) begin
            @(negedge clk);
            sample_issue(j);
            apply_step(idle, j);
            j++;
        end
        repeat (4) begin // Quiet cycles catch late duplicate issues
            @(negedge clk);
            sample_issue(j);
            apply_step(idle, j);
            j++;
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hdl/int_issue_pkg.sv
hdl/int_issue_bank.sv
hdl/bank_order_sort.sv
hdl/branch_classifier.sv
hdl/int_issue_queue.sv
hdl/phys_regfile.sv
hdl/int_issue_top.sv
verification/int_issue_tb.sv

//--- Bender.yml
package:
  name: int_issue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/int_issue_pkg.sv
      - hdl/int_issue_bank.sv
      - hdl/bank_order_sort.sv
      - hdl/branch_classifier.sv
      - hdl/int_issue_queue.sv
      - hdl/phys_regfile.sv
      - hdl/int_issue_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/int_issue_tb.sv
